/* verilog.f */
+incdir+include
verilog/glb_types_pkg.sv
verilog/glb_addr_pkg.sv
verilog/cfg_ifc.sv
verilog/glb_bank.sv
verilog/glb_cfg_entry.sv
verilog/glb_tile_sram_cfg_ctrl.sv
verilog/glb_cfg_chain_end.sv
verilog/glb_top.sv
tests/glb_tb.sv

/* tests/glb_tb.sv */
// global buffer config testbench: directed write, read, latency and error tests on glb_top
`timescale 1ns/1ps
`include "glb_config.svh"

module glb_tb;
    import glb_types_pkg::*;
    import glb_addr_pkg::*;

    localparam int TIMEOUT_CYCLES = 40;

    logic      clk;
    logic      reset;
    logic      req;
    cfg_op_e   op;
    cfg_addr_t addr;
    cfg_data_t wdata;
    logic      rsp_valid;
    cfg_data_t rdata;
    logic      rd_drop_err;
    logic      addr_err;

    // reference contents, one word per config address
    cfg_data_t model [1 << ADDR_BITS];

    int errors;
    int pass_count;
    int fail_count;

    glb_top u_glb_top (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .op          (op),
        .addr        (addr),
        .wdata       (wdata),
        .rsp_valid   (rsp_valid),
        .rdata       (rdata),
        .rd_drop_err (rd_drop_err),
        .addr_err    (addr_err)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_data(input string name, input cfg_data_t exp, input cfg_data_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // one strobe cycle, starting at a rising edge
    task automatic drive_req(input cfg_op_e o, input cfg_addr_t a, input cfg_data_t d);
        @(posedge clk);
        req   <= 1'b1;
        op    <= o;
        addr  <= a;
        wdata <= d;
        if (o == CFG_WRITE) model[a] = d;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        req <= 1'b0;
        op  <= CFG_NOP;
    endtask

    // latency counts cycles from the strobe cycle to rsp_valid
    task automatic read_word(input cfg_addr_t a, output cfg_data_t d, output int lat);
        int cnt;
        bit found;
        drive_req(CFG_READ, a, '0);
        drive_idle();
        cnt   = 1;
        found = 0;
        d     = '0;
        lat   = -1;
        while (!found && cnt <= TIMEOUT_CYCLES) begin
            // sample mid-cycle away from the edge
            @(negedge clk);
            if (rsp_valid) begin
                found = 1;
                d     = rdata;
                lat   = cnt;
            end else begin
                cnt++;
            end
        end
        if (!found) begin
            $display("timeout: no response within %0d cycles to a read of address %h",
                     TIMEOUT_CYCLES, a);
            errors++;
        end
    endtask

    task automatic report(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %s: ok", name);
            pass_count++;
        end else begin
            $display("test %s: %0d errors", name, errors - errs_before);
            fail_count++;
        end
    endtask

    // word 0 of every bank in every tile
    task automatic write_then_read_back();
        int e0;
        cfg_addr_t a;
        cfg_data_t d;
        int lat;
        e0 = errors;
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            for (int b = 0; b < `GLB_BANKS_PER_TILE; b++) begin
                a = make_addr(tile_id_t'(t), bank_id_t'(b), '0);
                drive_req(CFG_WRITE, a, 32'hc0de_0000 + (t << 8) + b);
                drive_idle();
            end
        end
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            for (int b = 0; b < `GLB_BANKS_PER_TILE; b++) begin
                a = make_addr(tile_id_t'(t), bank_id_t'(b), '0);
                read_word(a, d, lat);
                check_data("rdata", model[a], d);
            end
        end
        report("write_read", e0);
    endtask

    // two cycles more per tile hop
    task automatic measure_read_latency();
        int e0;
        cfg_data_t d;
        int lat;
        e0 = errors;
        for (int k = 0; k < `GLB_NUM_TILES; k++) begin
            read_word(make_addr(tile_id_t'(k), '0, '0), d, lat);
            check_latency("latency", 4 + 2 * k, lat);
        end
        report("latency", e0);
    endtask

    // tile 5 is past the end of the chain
    task automatic read_unclaimed_tile();
        int e0;
        cfg_data_t d;
        int lat;
        e0 = errors;
        check_flag("addr_err", 1'b0, addr_err);
        read_word(make_addr(tile_id_t'(5), '0, '0), d, lat);
        check_data("rdata", '0, d);
        check_latency("latency", 4 + 2 * `GLB_NUM_TILES, lat);
        check_flag("addr_err", 1'b1, addr_err);
        report("unclaimed", e0);
    endtask

    // second read lands while the first is open
    task automatic drop_second_read();
        int e0;
        int n;
        cfg_addr_t a3;
        cfg_data_t first;
        e0    = errors;
        n     = 0;
        first = '0;
        a3    = make_addr(tile_id_t'(3), '0, '0);
        // no read has overlapped another so far
        check_flag("rd_drop_err", 1'b0, rd_drop_err);
        drive_req(CFG_READ, a3, '0);
        drive_idle();
        drive_req(CFG_READ, make_addr('0, '0, '0), '0);
        drive_idle();
        // window covers both possible returns
        for (int c = 0; c < TIMEOUT_CYCLES; c++) begin
            @(negedge clk);
            if (rsp_valid) begin
                if (n == 0) first = rdata;
                n++;
            end
        end
        if (n != 1) begin
            $display("expected exactly one read response, saw %0d", n);
            errors++;
        end
        check_data("rdata", model[a3], first);
        check_flag("rd_drop_err", 1'b1, rd_drop_err);
        report("dropped_read", e0);
    endtask

    // back to back writes, then read each one
    task automatic read_after_write_burst();
        int e0;
        cfg_addr_t addrs [$];
        cfg_addr_t a;
        cfg_data_t d;
        int lat;
        e0 = errors;
        for (int i = 0; i < 20; i++) begin
            a = make_addr(tile_id_t'($urandom_range(0, `GLB_NUM_TILES - 1)),
                          bank_id_t'($urandom_range(0, `GLB_BANKS_PER_TILE - 1)),
                          word_addr_t'($urandom_range(0, (1 << `GLB_BANK_ADDR_BITS) - 1)));
            addrs.push_back(a);
            // model keeps the later write
            drive_req(CFG_WRITE, a, cfg_data_t'($urandom));
        end
        drive_idle();
        foreach (addrs[i]) begin
            read_word(addrs[i], d, lat);
            check_data("rdata", model[addrs[i]], d);
        end
        report("writes_in_flight", e0);
    endtask

    initial begin
        req        = 1'b0;
        op         = CFG_NOP;
        addr       = '0;
        wdata      = '0;
        reset      = 1'b1;
        errors     = 0;
        pass_count = 0;
        fail_count = 0;
        void'($urandom(61));
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        write_then_read_back();
        measure_read_latency();
        read_unclaimed_tile();
        drop_second_read();
        read_after_write_burst();

        $display("summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* verilog/glb_top.sv */
// global buffer config top: entry, chain of sram tiles, chain terminator
`timescale 1ns/1ps
`include "glb_config.svh"

module glb_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req,
    input  glb_types_pkg::cfg_op_e   op,
    input  glb_addr_pkg::cfg_addr_t  addr,
    input  glb_types_pkg::cfg_data_t wdata,
    output logic                     rsp_valid,
    output glb_types_pkg::cfg_data_t rdata,
    output logic                     rd_drop_err,
    output logic                     addr_err
);

    // hop i feeds tile i, last hop feeds the terminator
    cfg_ifc chain [`GLB_NUM_TILES+1] ();

    glb_cfg_entry u_entry (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .op          (op),
        .addr        (addr),
        .wdata       (wdata),
        .rsp_valid   (rsp_valid),
        .rdata       (rdata),
        .rd_drop_err (rd_drop_err),
        .chain       (chain[0])
    );

    generate
        for (genvar t = 0; t < `GLB_NUM_TILES; t++) begin : g_tile
            glb_tile_sram_cfg_ctrl #(
                .TILE_ID (t)
            ) u_tile (
                .clk   (clk),
                .reset (reset),
                .west  (chain[t]),
                .east  (chain[t+1])
            );
        end
    endgenerate

    glb_cfg_chain_end u_chain_end (
        .clk      (clk),
        .reset    (reset),
        .addr_err (addr_err),
        .west     (chain[`GLB_NUM_TILES])
    );

endmodule

/* verilog/glb_cfg_chain_end.sv */
// config chain terminator: flags unclaimed requests and answers their reads with zero
`timescale 1ns/1ps

module glb_cfg_chain_end (
    input  logic  clk,
    input  logic  reset,
    output logic  addr_err,
    cfg_ifc.slave west
);

    // read seen last cycle, stands in for a bank access
    logic rd_seen;

    // nothing to read back here
    assign west.rd_data = '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_seen            <= 1'b0;
            west.rd_data_valid <= 1'b0;
            addr_err           <= 1'b0;
        end else begin
            // two stages, so an unclaimed read lines up like one more tile
            rd_seen            <= west.rd_en;
            west.rd_data_valid <= rd_seen;
            // anything arriving here missed every tile, sticky
            if (west.wr_en || west.rd_en) addr_err <= 1'b1;
        end
    end

endmodule

/* verilog/glb_tile_sram_cfg_ctrl.sv */
// tile sram config controller: claims requests for its own banks, forwards the rest east
`timescale 1ns/1ps
`include "glb_config.svh"

module glb_tile_sram_cfg_ctrl #(
    parameter int TILE_ID = 0
) (
    input  logic   clk,
    input  logic   reset,
    cfg_ifc.slave  west,
    cfg_ifc.master east
);
    import glb_types_pkg::*;
    import glb_addr_pkg::*;

    logic       claim;
    word_addr_t word;
    bank_id_t   bank;
    logic       bank_wr_en   [`GLB_BANKS_PER_TILE];
    logic       bank_rd_en   [`GLB_BANKS_PER_TILE];
    cfg_data_t  bank_rd_data [`GLB_BANKS_PER_TILE];
    // local read in its bank cycle, and which bank
    logic       local_rd_valid;
    bank_id_t   local_rd_bank;

    // tile field picks the owner
    assign claim = (tile_of(west.addr) == tile_id_t'(TILE_ID));
    assign word  = word_of(west.addr);
    assign bank  = bank_of(west.addr);

    generate
        for (genvar i = 0; i < `GLB_BANKS_PER_TILE; i++) begin : g_bank
            // steer claimed strobes by bank field
            assign bank_wr_en[i] = west.wr_en && claim && (bank == bank_id_t'(i));
            assign bank_rd_en[i] = west.rd_en && claim && (bank == bank_id_t'(i));

            glb_bank u_bank (
                .clk     (clk),
                .wr_en   (bank_wr_en[i]),
                .rd_en   (bank_rd_en[i]),
                .word    (word),
                .wr_data (west.wr_data),
                .rd_data (bank_rd_data[i])
            );
        end
    endgenerate

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            east.wr_en         <= 1'b0;
            east.rd_en         <= 1'b0;
            east.addr          <= '0;
            east.wr_data       <= '0;
            local_rd_valid     <= 1'b0;
            local_rd_bank      <= '0;
            west.rd_data       <= '0;
            west.rd_data_valid <= 1'b0;
        end else begin
            // unclaimed requests go one hop east
            east.wr_en   <= west.wr_en && !claim;
            east.rd_en   <= west.rd_en && !claim;
            east.addr    <= west.addr;
            east.wr_data <= west.wr_data;

            // bank output valid the cycle after its rd_en
            local_rd_valid <= west.rd_en && claim;
            local_rd_bank  <= bank;

            // merged return, local bank or east neighbour
            west.rd_data       <= local_rd_valid ? bank_rd_data[local_rd_bank] : east.rd_data;
            west.rd_data_valid <= local_rd_valid || east.rd_data_valid;
        end
    end

    a_west_one_strobe: assert property (
        @(posedge clk) disable iff (reset)
        !(west.wr_en && west.rd_en)
    );

    // holds while the entry keeps one read open
    a_no_return_clash: assert property (
        @(posedge clk) disable iff (reset)
        !(local_rd_valid && east.rd_data_valid)
    );

endmodule

/* verilog/glb_cfg_entry.sv */
// config entry: registers host requests onto the chain and tracks the single open read
`timescale 1ns/1ps

module glb_cfg_entry (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req,
    input  glb_types_pkg::cfg_op_e  op,
    input  glb_addr_pkg::cfg_addr_t addr,
    input  glb_types_pkg::cfg_data_t wdata,
    output logic                    rsp_valid,
    output glb_types_pkg::cfg_data_t rdata,
    output logic                    rd_drop_err,
    cfg_ifc.master                  chain
);
    import glb_types_pkg::*;

    entry_state_e state;
    entry_state_e state_next;
    logic         rd_req;
    logic         rd_accept;
    logic         rd_drop;

    assign rd_req    = req && (op == CFG_READ);
    // only one read on the chain at a time
    assign rd_accept = rd_req && (state == ENTRY_IDLE);
    assign rd_drop   = rd_req && (state == ENTRY_READ_WAIT);

    always_comb begin
        state_next = state;
        case (state)
            ENTRY_IDLE:      if (rd_accept) state_next = ENTRY_READ_WAIT;
            // return strobe closes the read
            ENTRY_READ_WAIT: if (chain.rd_data_valid) state_next = ENTRY_IDLE;
            default:         state_next = ENTRY_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= ENTRY_IDLE;
            chain.wr_en <= 1'b0;
            chain.rd_en <= 1'b0;
            rsp_valid   <= 1'b0;
            rd_drop_err <= 1'b0;
        end else begin
            state       <= state_next;
            // writes never blocked
            chain.wr_en <= req && (op == CFG_WRITE);
            chain.rd_en <= rd_accept;
            rsp_valid   <= chain.rd_data_valid;
            // sticky until reset
            if (rd_drop) rd_drop_err <= 1'b1;
        end
    end

    // request payload, qualified by the strobes
    always_ff @(posedge clk) begin
        chain.addr    <= addr;
        chain.wr_data <= wdata;
        if (chain.rd_data_valid) rdata <= chain.rd_data;
    end

    // a return with no read open means the chain invented a response
    a_rtn_only_when_waiting: assert property (
        @(posedge clk) disable iff (reset)
        chain.rd_data_valid |-> (state == ENTRY_READ_WAIT)
    );

endmodule

/* verilog/glb_bank.sv */
// sram bank model: single port, synchronous write, one-cycle registered read
`timescale 1ns/1ps

module glb_bank (
    input  logic                      clk,
    input  logic                      wr_en,
    input  logic                      rd_en,
    input  glb_addr_pkg::word_addr_t  word,
    input  glb_types_pkg::cfg_data_t  wr_data,
    output glb_types_pkg::cfg_data_t  rd_data
);
    import glb_types_pkg::*;
    import glb_addr_pkg::*;

    localparam int DEPTH = 1 << $bits(word_addr_t);

    // contents undefined until written, as in a macro
    cfg_data_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[word] <= wr_data;
        end
    end

    // output register holds between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[word];
        end
    end

endmodule

/* verilog/cfg_ifc.sv */
// config bus between chain stages: request strobes eastward, read return westward
`timescale 1ns/1ps

interface cfg_ifc;
    import glb_types_pkg::*;
    import glb_addr_pkg::*;

    // request, travels east
    logic      wr_en;
    logic      rd_en;
    cfg_addr_t addr;
    cfg_data_t wr_data;

    // read return, travels west
    cfg_data_t rd_data;
    logic      rd_data_valid;

    // upstream side of a hop
    modport master (
        output wr_en, rd_en, addr, wr_data,
        input  rd_data, rd_data_valid
    );

    // downstream side of a hop
    modport slave (
        input  wr_en, rd_en, addr, wr_data,
        output rd_data, rd_data_valid
    );

endinterface

/* verilog/glb_addr_pkg.sv */
// global buffer config address layout: tile, bank and word fields and their extraction
`include "glb_config.svh"

package glb_addr_pkg;

    localparam int BANK_ID_BITS = $clog2(`GLB_BANKS_PER_TILE);
    // field positions, word in the low bits
    localparam int BANK_LSB  = `GLB_BANK_ADDR_BITS;
    localparam int TILE_LSB  = BANK_LSB + BANK_ID_BITS;
    localparam int ADDR_BITS = TILE_LSB + `GLB_TILE_ID_BITS;

    typedef logic [`GLB_TILE_ID_BITS-1:0]   tile_id_t;
    typedef logic [BANK_ID_BITS-1:0]        bank_id_t;
    typedef logic [`GLB_BANK_ADDR_BITS-1:0] word_addr_t;
    // {tile, bank, word}
    typedef logic [ADDR_BITS-1:0]           cfg_addr_t;

    function automatic tile_id_t tile_of(cfg_addr_t a);
        return a[TILE_LSB +: `GLB_TILE_ID_BITS];
    endfunction

    function automatic bank_id_t bank_of(cfg_addr_t a);
        return a[BANK_LSB +: BANK_ID_BITS];
    endfunction

    function automatic word_addr_t word_of(cfg_addr_t a);
        return a[`GLB_BANK_ADDR_BITS-1:0];
    endfunction

    // inverse of the three above
    function automatic cfg_addr_t make_addr(tile_id_t t, bank_id_t b, word_addr_t w);
        return {t, b, w};
    endfunction

endpackage

/* verilog/glb_types_pkg.sv */
// global buffer config types: request opcodes, entry read tracker states, data word
`include "glb_config.svh"

package glb_types_pkg;

    // host request opcode
    typedef enum logic [1:0] {
        CFG_NOP   = 2'd0,
        CFG_WRITE = 2'd1,
        CFG_READ  = 2'd2
    } cfg_op_e;

    // entry tracks at most one read in flight
    typedef enum logic [0:0] {
        ENTRY_IDLE      = 1'b0,
        ENTRY_READ_WAIT = 1'b1
    } entry_state_e;

    // config data word, same width as a bank word
    typedef logic [`GLB_DATA_BITS-1:0] cfg_data_t;

endpackage

/* include/glb_config.svh */
// global buffer config path sizing: tile count, bank geometry and data width
`ifndef GLB_CONFIG_SVH
`define GLB_CONFIG_SVH

// tiles in the config daisy chain
`define GLB_NUM_TILES 4

// sram banks owned by each tile
`define GLB_BANKS_PER_TILE 2

// word address bits inside one bank
`define GLB_BANK_ADDR_BITS 6

// config data word width
`define GLB_DATA_BITS 32

// tile field of a config address
// wider than the tile count needs, so some addresses hit no tile
`define GLB_TILE_ID_BITS 3

`endif
